// File: Bender.yml
package:
  name: regf

sources:
  - include_dirs:
      - include
    files:
      - rtl/regf_pkg.sv
      - rtl/regf_block_ram.sv
      - rtl/regf_apb_decode.sv
      - rtl/regf_execute.sv
      - rtl/regf_result.sv
      - rtl/regf_top.sv
      - target: simulation
        files:
          - tb/regf_tb.sv

// File: include/regf_config.svh
`ifndef REGF_CONFIG_SVH
`define REGF_CONFIG_SVH

// --------------------------------------------------
// Register file geometry
// --------------------------------------------------

// Width of one register word
`define REGF_DATA_WDT           32
// Width of a physical register index
`define REGF_ADDR_WDT           6
// Physical registers, banked ones included
`define REGF_DEPTH              40

// --------------------------------------------------
// APB address map
// --------------------------------------------------

// Byte address width seen on APB
`define REGF_APB_AW             12

// Register window covers 0x000 to 0x0FC, index in paddr[7:2]
`define REGF_OFS_STAGE_A_IDX    12'h100
`define REGF_OFS_STAGE_B_IDX    12'h104
`define REGF_OFS_STAGE_A_DATA   12'h108
`define REGF_OFS_STAGE_B_DATA   12'h10C
`define REGF_OFS_COMMIT         12'h110
`define REGF_OFS_COUNT          12'h114

`endif

// File: rtl/regf_apb_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "regf_config.svh"

module regf_apb_decode
(
        input  wire                             i_clk_multipump,
        input  wire                             i_rst_n,

        // APB request side
        input  wire                             i_psel,
        input  wire                             i_penable,
        input  wire                             i_pwrite,
        input  wire     [`REGF_APB_AW-1:0]      i_paddr,
        input  wire     regf_pkg::reg_word_t    i_pwdata,
        input  wire                             i_pready,

        // Issued operation
        output regf_pkg::regf_op_e              o_op,
        output regf_pkg::reg_idx_t              o_idx,
        output logic                            o_sel_b,
        output logic    [1:0]                   o_data_sel,
        output logic                            o_err
);

import regf_pkg::*;

logic           penable_q;
logic           first_acc;
logic           aligned;
reg_idx_t       win_idx;

// --------------------------------------------------
// First access cycle detect
// --------------------------------------------------

// Previous access phase
always_ff @(posedge i_clk_multipump or negedge i_rst_n)
begin
        if (!i_rst_n)
                penable_q <= 1'b0;
        else
                penable_q <= i_psel & i_penable;
end

// Access phase just entered, no ready seen yet
assign first_acc = i_psel & i_penable & ~penable_q & ~i_pready;

// Window index from word address
assign win_idx = i_paddr[7:2];
assign aligned = (i_paddr[1:0] == 2'b00);

// --------------------------------------------------
// Address map classify
// --------------------------------------------------

always_comb
begin
        o_op       = OP_NONE;
        o_idx      = '0;
        o_sel_b    = 1'b0;
        o_data_sel = DSEL_NONE;
        o_err      = 1'b0;

        if (first_acc)
        begin
                if (!aligned)
                        o_err = 1'b1;
                else if (i_paddr[`REGF_APB_AW-1:8] == '0)
                begin
                        // Window, only the physical registers exist
                        if (win_idx >= `REGF_DEPTH)
                                o_err = 1'b1;
                        else
                        begin
                                o_op  = i_pwrite ? OP_WIN_WR : OP_WIN_RD;
                                o_idx = win_idx;
                        end
                end
                else
                begin
                        case (i_paddr)
                        `REGF_OFS_STAGE_A_IDX, `REGF_OFS_STAGE_B_IDX:
                        begin
                                // Staged index must name a real register
                                if (i_pwrite && (i_pwdata >= `REGF_DEPTH))
                                        o_err = 1'b1;
                                else
                                begin
                                        o_op       = i_pwrite ? OP_STAGE_WR : OP_STAGE_RD;
                                        // B slots sit at the odd word
                                        o_sel_b    = i_paddr[2];
                                        o_data_sel = DSEL_IDX;
                                end
                        end
                        `REGF_OFS_STAGE_A_DATA, `REGF_OFS_STAGE_B_DATA:
                        begin
                                o_op       = i_pwrite ? OP_STAGE_WR : OP_STAGE_RD;
                                o_sel_b    = i_paddr[2];
                                o_data_sel = DSEL_DATA;
                        end
                        `REGF_OFS_COMMIT:
                        begin
                                // Read back is a staged read with no field, hence zero
                                o_op = i_pwrite ? OP_COMMIT : OP_STAGE_RD;
                        end
                        `REGF_OFS_COUNT:
                        begin
                                if (i_pwrite)
                                        o_err = 1'b1;
                                else
                                        o_op = OP_COUNT_RD;
                        end
                        default:
                                o_err = 1'b1;
                        endcase
                end
        end
end

endmodule

`default_nettype wire

// File: rtl/regf_block_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "regf_config.svh"

module regf_block_ram
(
        input  wire     i_clk_multipump,

        // Port A also supplies the read address
        input  wire     regf_pkg::reg_idx_t     i_addr_a,
        input  wire     regf_pkg::reg_idx_t     i_addr_b,

        input  wire                             i_wen,

        input  wire     regf_pkg::reg_word_t    i_wr_data_a,
        input  wire     regf_pkg::reg_word_t    i_wr_data_b,

        output regf_pkg::reg_word_t             o_rd_data_a
);

import regf_pkg::*;

// Storage array
reg_word_t mem [0:`REGF_DEPTH-1];

// Contents start at zero, reset leaves them alone
initial
begin
        for (int i = 0; i < `REGF_DEPTH; i++)
                mem[i] = '0;
end

// Both ports write on one edge
// Port B comes last so it wins on equal addresses
always @(posedge i_clk_multipump)
begin
        if (i_wen)
        begin
                mem[i_addr_a] <= i_wr_data_a;
                mem[i_addr_b] <= i_wr_data_b;
        end
end

// Registered read, one cycle after addr_a
always_ff @(posedge i_clk_multipump)
begin
        o_rd_data_a <= mem[i_addr_a];
end

endmodule

`default_nettype wire

// File: rtl/regf_execute.sv
`timescale 1ns/1ps
`default_nettype none

module regf_execute
(
        input  wire                             i_clk_multipump,
        input  wire                             i_rst_n,

        // From decode
        input  wire     regf_pkg::regf_op_e     i_op,
        input  wire     regf_pkg::reg_idx_t     i_idx,
        input  wire                             i_sel_b,
        input  wire     [1:0]                   i_data_sel,
        input  wire     regf_pkg::reg_word_t    i_wdata,

        // RAM ports
        output regf_pkg::reg_idx_t              o_ram_addr_a,
        output regf_pkg::reg_idx_t              o_ram_addr_b,
        output logic                            o_ram_wen,
        output regf_pkg::reg_word_t             o_ram_data_a,
        output regf_pkg::reg_word_t             o_ram_data_b,

        // To result
        output regf_pkg::reg_word_t             o_stage_rd,
        output regf_pkg::commit_cnt_t           o_commit_cnt
);

import regf_pkg::*;

reg_idx_t       stage_a_idx;
reg_idx_t       stage_b_idx;
reg_word_t      stage_a_data;
reg_word_t      stage_b_data;
reg_word_t      stage_sel;

// --------------------------------------------------
// Staging registers
// --------------------------------------------------

always_ff @(posedge i_clk_multipump or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                stage_a_idx  <= '0;
                stage_b_idx  <= '0;
                stage_a_data <= '0;
                stage_b_data <= '0;
        end
        else if (i_op == OP_STAGE_WR)
        begin
                case ({i_sel_b, i_data_sel})
                {1'b0, DSEL_IDX}:  stage_a_idx  <= i_wdata[$bits(reg_idx_t)-1:0];
                {1'b1, DSEL_IDX}:  stage_b_idx  <= i_wdata[$bits(reg_idx_t)-1:0];
                {1'b0, DSEL_DATA}: stage_a_data <= i_wdata;
                {1'b1, DSEL_DATA}: stage_b_data <= i_wdata;
                default: ;
                endcase
        end
end

// Field picked for a staged read, zero with no field
always_comb
begin
        case ({i_sel_b, i_data_sel})
        {1'b0, DSEL_IDX}:  stage_sel = reg_word_t'(stage_a_idx);
        {1'b1, DSEL_IDX}:  stage_sel = reg_word_t'(stage_b_idx);
        {1'b0, DSEL_DATA}: stage_sel = stage_a_data;
        {1'b1, DSEL_DATA}: stage_sel = stage_b_data;
        default:           stage_sel = '0;
        endcase
end

// Held for the ready cycle
always_ff @(posedge i_clk_multipump)
begin
        if (i_op == OP_STAGE_RD)
                o_stage_rd <= stage_sel;
end

// Commit counter, wraps
always_ff @(posedge i_clk_multipump or negedge i_rst_n)
begin
        if (!i_rst_n)
                o_commit_cnt <= '0;
        else if (i_op == OP_COMMIT)
                o_commit_cnt <= o_commit_cnt + 1'b1;
end

// --------------------------------------------------
// RAM port steering
// --------------------------------------------------

always_comb
begin
        // Window access drives one index and one word on both ports
        o_ram_addr_a = i_idx;
        o_ram_addr_b = i_idx;
        o_ram_data_a = i_wdata;
        o_ram_data_b = i_wdata;
        o_ram_wen    = 1'b0;

        case (i_op)
        OP_WIN_WR:
                o_ram_wen = 1'b1;
        OP_COMMIT:
        begin
                // Two write-backs in one RAM cycle
                o_ram_addr_a = stage_a_idx;
                o_ram_addr_b = stage_b_idx;
                o_ram_data_a = stage_a_data;
                o_ram_data_b = stage_b_data;
                o_ram_wen    = 1'b1;
        end
        default: ;
        endcase
end

endmodule

`default_nettype wire

// File: rtl/regf_pkg.sv
`default_nettype none

`include "regf_config.svh"

package regf_pkg;

        // Physical register index
        typedef logic [`REGF_ADDR_WDT-1:0] reg_idx_t;

        // One register word
        typedef logic [`REGF_DATA_WDT-1:0] reg_word_t;

        // Commit counter, wraps at 16 bits
        typedef logic [15:0] commit_cnt_t;

        // One operation per APB access
        typedef enum logic [2:0]
        {
                OP_NONE         = 3'd0,
                OP_WIN_RD       = 3'd1,
                OP_WIN_WR       = 3'd2,
                OP_STAGE_RD     = 3'd3,
                OP_STAGE_WR     = 3'd4,
                OP_COMMIT       = 3'd5,
                OP_COUNT_RD     = 3'd6
        } regf_op_e;

        // Staging field select, index half or data half
        localparam logic [1:0] DSEL_NONE = 2'b00;
        localparam logic [1:0] DSEL_IDX  = 2'b01;
        localparam logic [1:0] DSEL_DATA = 2'b10;

endpackage

`default_nettype wire

// File: rtl/regf_result.sv
`timescale 1ns/1ps
`default_nettype none

module regf_result
(
        input  wire                             i_clk_multipump,
        input  wire                             i_rst_n,

        // Issued operation from decode
        input  wire     regf_pkg::regf_op_e     i_op,
        input  wire                             i_err,

        // Read sources
        input  wire     regf_pkg::reg_word_t    i_ram_rd_data,
        input  wire     regf_pkg::reg_word_t    i_stage_rd,
        input  wire     regf_pkg::commit_cnt_t  i_commit_cnt,

        // APB response
        output regf_pkg::reg_word_t             o_prdata,
        output logic                            o_pready,
        output logic                            o_pslverr
);

import regf_pkg::*;

logic           issue;
logic           pending_q;
regf_op_e       op_q;
logic           err_q;
reg_word_t      rd_sel;

// Legal op or flagged error, only on the first access cycle
assign issue = (i_op != OP_NONE) | i_err;

// --------------------------------------------------
// Wait state
// --------------------------------------------------

always_ff @(posedge i_clk_multipump or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                pending_q <= 1'b0;
                op_q      <= OP_NONE;
                err_q     <= 1'b0;
        end
        else
        begin
                // High for exactly one cycle
                pending_q <= issue;
                if (issue)
                begin
                        op_q  <= i_op;
                        err_q <= i_err;
                end
        end
end

// --------------------------------------------------
// Read data select
// --------------------------------------------------

always_comb
begin
        rd_sel = '0;
        if (!err_q)
        begin
                case (op_q)
                OP_WIN_RD:   rd_sel = i_ram_rd_data;
                OP_STAGE_RD: rd_sel = i_stage_rd;
                OP_COUNT_RD: rd_sel = reg_word_t'(i_commit_cnt);
                default: ;
                endcase
        end
end

// Response valid only in the ready cycle
assign o_pready  = pending_q;
assign o_pslverr = pending_q & err_q;
assign o_prdata  = pending_q ? rd_sel : '0;

endmodule

`default_nettype wire

// File: rtl/regf_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regf_config.svh"

module regf_top
(
        input  wire                             i_clk_multipump,
        input  wire                             i_rst_n,

        // APB slave
        input  wire                             i_psel,
        input  wire                             i_penable,
        input  wire                             i_pwrite,
        input  wire     [`REGF_APB_AW-1:0]      i_paddr,
        input  wire     regf_pkg::reg_word_t    i_pwdata,
        output regf_pkg::reg_word_t             o_prdata,
        output logic                            o_pready,
        output logic                            o_pslverr
);

import regf_pkg::*;

// Decode to execute and result
regf_op_e       op;
reg_idx_t       idx;
logic           sel_b;
logic [1:0]     data_sel;
logic           err;

// Execute to RAM
reg_idx_t       ram_addr_a;
reg_idx_t       ram_addr_b;
logic           ram_wen;
reg_word_t      ram_data_a;
reg_word_t      ram_data_b;

// Read sources for result
reg_word_t      ram_rd_data;
reg_word_t      stage_rd;
commit_cnt_t    commit_cnt;

// --------------------------------------------------
// Decode, execute, memory, response
// --------------------------------------------------

regf_apb_decode u_decode
(
        .i_clk_multipump        (i_clk_multipump),
        .i_rst_n                (i_rst_n),
        .i_psel                 (i_psel),
        .i_penable              (i_penable),
        .i_pwrite               (i_pwrite),
        .i_paddr                (i_paddr),
        .i_pwdata               (i_pwdata),
        .i_pready               (o_pready),
        .o_op                   (op),
        .o_idx                  (idx),
        .o_sel_b                (sel_b),
        .o_data_sel             (data_sel),
        .o_err                  (err)
);

regf_execute u_execute
(
        .i_clk_multipump        (i_clk_multipump),
        .i_rst_n                (i_rst_n),
        .i_op                   (op),
        .i_idx                  (idx),
        .i_sel_b                (sel_b),
        .i_data_sel             (data_sel),
        .i_wdata                (i_pwdata),
        .o_ram_addr_a           (ram_addr_a),
        .o_ram_addr_b           (ram_addr_b),
        .o_ram_wen              (ram_wen),
        .o_ram_data_a           (ram_data_a),
        .o_ram_data_b           (ram_data_b),
        .o_stage_rd             (stage_rd),
        .o_commit_cnt           (commit_cnt)
);

regf_block_ram u_ram
(
        .i_clk_multipump        (i_clk_multipump),
        .i_addr_a               (ram_addr_a),
        .i_addr_b               (ram_addr_b),
        .i_wen                  (ram_wen),
        .i_wr_data_a            (ram_data_a),
        .i_wr_data_b            (ram_data_b),
        .o_rd_data_a            (ram_rd_data)
);

regf_result u_result
(
        .i_clk_multipump        (i_clk_multipump),
        .i_rst_n                (i_rst_n),
        .i_op                   (op),
        .i_err                  (err),
        .i_ram_rd_data          (ram_rd_data),
        .i_stage_rd             (stage_rd),
        .i_commit_cnt           (commit_cnt),
        .o_prdata               (o_prdata),
        .o_pready               (o_pready),
        .o_pslverr              (o_pslverr)
);

endmodule

`default_nettype wire

// File: tb/regf_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regf_config.svh"

module regf_tb;

import regf_pkg::*;

// --------------------------------------------------
// Run length and watchdog budget
// --------------------------------------------------

localparam int CLK_PERIOD      = 20;
localparam int N_RAND_WR       = 64;
localparam int N_COMMIT_ROUNDS = 16;
localparam int WRAP_COMMITS    = 65536;
localparam int N_UNMAPPED      = 4;
localparam int N_BAD_WIN       = (1 << `REGF_ADDR_WDT) - `REGF_DEPTH;
// Access cycles allowed before giving up on ready
localparam int MAX_ACC         = 8;

// Transfers per phase at four clock cycles each
localparam int N_XFERS = (`REGF_DEPTH + 5)
                       + (3 * `REGF_DEPTH + 2 * N_RAND_WR)
                       + (12 * N_COMMIT_ROUNDS + 8)
                       + (WRAP_COMMITS + 2)
                       + (2 * N_BAD_WIN + 4 + 2 + 2 * N_UNMAPPED + `REGF_DEPTH + 5);
localparam int WATCHDOG_NS = N_XFERS * 4 * CLK_PERIOD + 1000;

logic                           clk;
logic                           rst_n;
logic                           psel;
logic                           penable;
logic                           pwrite;
logic   [`REGF_APB_AW-1:0]      paddr;
reg_word_t                      pwdata;
reg_word_t                      prdata;
logic                           pready;
logic                           pslverr;

// Reference model state
reg_word_t      model_regs [0:`REGF_DEPTH-1];
reg_idx_t       model_a_idx;
reg_idx_t       model_b_idx;
reg_word_t      model_a_data;
reg_word_t      model_b_data;
commit_cnt_t    model_cnt;

int             errors;
int             n_transfers;

regf_top u_regf_top
(
        .i_clk_multipump        (clk),
        .i_rst_n                (rst_n),
        .i_psel                 (psel),
        .i_penable              (penable),
        .i_pwrite               (pwrite),
        .i_paddr                (paddr),
        .i_pwdata               (pwdata),
        .o_prdata               (prdata),
        .o_pready               (pready),
        .o_pslverr              (pslverr)
);

// 20 ns clock
initial
        clk = 1'b0;
always #(CLK_PERIOD / 2) clk = ~clk;

// --------------------------------------------------
// Checking helpers
// --------------------------------------------------

task automatic report_mismatch(input string sig, input reg_word_t exp_v, input reg_word_t act_v);
        $display("ERROR %0t ns: %s expected %h actual %h", $time, sig, exp_v, act_v);
        errors++;
endtask

// Some offsets that decode to nothing
function automatic logic [`REGF_APB_AW-1:0] unmapped_offset(input int k);
        case (k)
        0:       return 12'h118;
        1:       return 12'h1FC;
        2:       return 12'h200;
        default: return 12'hFFC;
        endcase
endfunction

// Predicts the response from the address map rules and updates the model
task automatic predict_access
(
        input  logic    [`REGF_APB_AW-1:0]      addr,
        input  logic                            write,
        input  reg_word_t                       wdata,
        output logic                            exp_err,
        output reg_word_t                       exp_rdata
);
        int idx;

        exp_err   = 1'b0;
        exp_rdata = '0;
        idx       = addr[7:2];
        if (addr[1:0] != 2'b00)
                exp_err = 1'b1;
        else if (addr < 12'h100)
        begin
                // Window beyond the physical registers
                if (idx >= `REGF_DEPTH)
                        exp_err = 1'b1;
                else if (write)
                        model_regs[idx] = wdata;
                else
                        exp_rdata = model_regs[idx];
        end
        else
        begin
                case (addr)
                `REGF_OFS_STAGE_A_IDX, `REGF_OFS_STAGE_B_IDX:
                begin
                        if (write && wdata >= `REGF_DEPTH)
                                exp_err = 1'b1;
                        else if (write && addr == `REGF_OFS_STAGE_A_IDX)
                                model_a_idx = wdata;
                        else if (write)
                                model_b_idx = wdata;
                        else if (addr == `REGF_OFS_STAGE_A_IDX)
                                exp_rdata = reg_word_t'(model_a_idx);
                        else
                                exp_rdata = reg_word_t'(model_b_idx);
                end
                `REGF_OFS_STAGE_A_DATA:
                        if (write)
                                model_a_data = wdata;
                        else
                                exp_rdata = model_a_data;
                `REGF_OFS_STAGE_B_DATA:
                        if (write)
                                model_b_data = wdata;
                        else
                                exp_rdata = model_b_data;
                `REGF_OFS_COMMIT:
                        if (write)
                        begin
                                // B lands last and wins on equal indices
                                model_regs[model_a_idx] = model_a_data;
                                model_regs[model_b_idx] = model_b_data;
                                model_cnt = model_cnt + 1'b1;
                        end
                `REGF_OFS_COUNT:
                        if (write)
                                exp_err = 1'b1;
                        else
                                exp_rdata = reg_word_t'(model_cnt);
                default:
                        exp_err = 1'b1;
                endcase
        end
endtask

// --------------------------------------------------
// APB master
// --------------------------------------------------

// Setup, access until ready, then idle; four cycles in all
task automatic run_transfer
(
        input logic     [`REGF_APB_AW-1:0]      addr,
        input logic                             write,
        input reg_word_t                        wdata
);
        logic           exp_err;
        reg_word_t      exp_rdata;
        int             acc_cycles;

        predict_access(addr, write, wdata, exp_err, exp_rdata);

        // Setup phase
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        assert (pready === 1'b0)
        else
                report_mismatch("o_pready", '0, reg_word_t'(pready));

        // Access phase, wait for ready
        @(posedge clk);
        #1;
        penable    = 1'b1;
        acc_cycles = 0;
        do
        begin
                @(negedge clk);
                acc_cycles++;
        end
        while (pready !== 1'b1 && acc_cycles < MAX_ACC);

        // Exactly one wait state
        assert (pready === 1'b1 && acc_cycles == 2)
        else
        begin
                $display("Transfer to %h saw o_pready after %0d access cycles, not 2 (t=%0t)",
                         addr, acc_cycles, $time);
                errors++;
        end
        assert (pslverr === exp_err)
        else
                report_mismatch("o_pslverr", reg_word_t'(exp_err), reg_word_t'(pslverr));
        if (!write || exp_err)
        begin
                assert (prdata === exp_rdata)
                else
                        report_mismatch("o_prdata", exp_rdata, prdata);
        end

        // Back to idle
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        n_transfers++;
endtask

task automatic apb_write(input logic [`REGF_APB_AW-1:0] addr, input reg_word_t data);
        run_transfer(addr, 1'b1, data);
endtask

task automatic apb_read(input logic [`REGF_APB_AW-1:0] addr);
        run_transfer(addr, 1'b0, '0);
endtask

// Whole register file, staging and counter
task automatic read_all_state;
        for (int i = 0; i < `REGF_DEPTH; i++)
                apb_read(i << 2);
        apb_read(`REGF_OFS_STAGE_A_IDX);
        apb_read(`REGF_OFS_STAGE_B_IDX);
        apb_read(`REGF_OFS_STAGE_A_DATA);
        apb_read(`REGF_OFS_STAGE_B_DATA);
        apb_read(`REGF_OFS_COUNT);
endtask

// --------------------------------------------------
// Watchdog
// --------------------------------------------------

initial
begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish in %0d ns, the DUT seems to hang", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
end

// --------------------------------------------------
// Stimulus
// --------------------------------------------------

initial
begin
        reg_idx_t       ia;
        reg_idx_t       ib;
        reg_word_t      da;
        reg_word_t      db;

        void'($urandom(32'hce6470ab));
        errors      = 0;
        n_transfers = 0;
        for (int i = 0; i < `REGF_DEPTH; i++)
                model_regs[i] = '0;
        model_a_idx  = '0;
        model_b_idx  = '0;
        model_a_data = '0;
        model_b_data = '0;
        model_cnt    = '0;

        // All inputs quiet during reset
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Response idle after reset
        @(negedge clk);
        assert (pready === 1'b0)
        else
                report_mismatch("o_pready", '0, reg_word_t'(pready));
        assert (pslverr === 1'b0)
        else
                report_mismatch("o_pslverr", '0, reg_word_t'(pslverr));
        assert (prdata === '0)
        else
                report_mismatch("o_prdata", '0, prdata);
        read_all_state();

        // Window writes each read straight back
        for (int i = 0; i < `REGF_DEPTH; i++)
        begin
                apb_write(i << 2, $urandom());
                apb_read(i << 2);
        end
        for (int i = 0; i < N_RAND_WR; i++)
        begin
                ia = $urandom_range(`REGF_DEPTH - 1, 0);
                apb_write(ia << 2, $urandom());
                apb_read(ia << 2);
        end
        for (int i = 0; i < `REGF_DEPTH; i++)
                apb_read(i << 2);

        // Staged pairs and commits
        for (int r = 0; r < N_COMMIT_ROUNDS; r++)
        begin
                ia = $urandom_range(`REGF_DEPTH - 1, 0);
                ib = $urandom_range(`REGF_DEPTH - 1, 0);
                da = $urandom();
                db = $urandom();
                apb_write(`REGF_OFS_STAGE_A_IDX, reg_word_t'(ia));
                apb_write(`REGF_OFS_STAGE_B_IDX, reg_word_t'(ib));
                apb_write(`REGF_OFS_STAGE_A_DATA, da);
                apb_write(`REGF_OFS_STAGE_B_DATA, db);
                apb_read(`REGF_OFS_STAGE_A_IDX);
                apb_read(`REGF_OFS_STAGE_B_IDX);
                apb_read(`REGF_OFS_STAGE_A_DATA);
                apb_read(`REGF_OFS_STAGE_B_DATA);
                apb_write(`REGF_OFS_COMMIT, '0);
                apb_read(ia << 2);
                apb_read(ib << 2);
                apb_read(`REGF_OFS_COUNT);
        end

        // Same target twice so B must stick
        ia = $urandom_range(`REGF_DEPTH - 1, 0);
        apb_write(`REGF_OFS_STAGE_A_IDX, reg_word_t'(ia));
        apb_write(`REGF_OFS_STAGE_B_IDX, reg_word_t'(ia));
        apb_write(`REGF_OFS_STAGE_A_DATA, $urandom());
        apb_write(`REGF_OFS_STAGE_B_DATA, $urandom());
        apb_write(`REGF_OFS_COMMIT, '0);
        apb_read(ia << 2);
        apb_read(`REGF_OFS_COUNT);
        apb_read(`REGF_OFS_COMMIT);

        // Full lap of the 16 bit counter
        for (int i = 0; i < WRAP_COMMITS; i++)
        begin
                apb_write(`REGF_OFS_COMMIT, '0);
                // Top value just before the wrap
                if (model_cnt == 16'hFFFF)
                        apb_read(`REGF_OFS_COUNT);
        end
        apb_read(`REGF_OFS_COUNT);

        // Illegal accesses
        for (int i = `REGF_DEPTH; i < (1 << `REGF_ADDR_WDT); i++)
        begin
                apb_write(i << 2, $urandom());
                apb_read(i << 2);
        end
        apb_write(`REGF_OFS_STAGE_A_IDX, `REGF_DEPTH + $urandom_range(1000, 0));
        apb_write(`REGF_OFS_STAGE_B_IDX, 32'hFFFF_FFFF);
        apb_read(`REGF_OFS_STAGE_A_IDX);
        apb_read(`REGF_OFS_STAGE_B_IDX);
        apb_write(`REGF_OFS_COUNT, $urandom());
        apb_read(`REGF_OFS_COUNT);
        for (int k = 0; k < N_UNMAPPED; k++)
        begin
                apb_write(unmapped_offset(k), $urandom());
                apb_read(unmapped_offset(k));
        end

        // Nothing above may have changed state
        read_all_state();

        $display("Transfers: %0d, errors: %0d", n_transfers, errors);
        if (errors == 0)
                $display("Simulation passed");
        else
                $display("Simulation failed");
        $finish;
end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
rtl/regf_pkg.sv
rtl/regf_block_ram.sv
rtl/regf_apb_decode.sv
rtl/regf_execute.sv
rtl/regf_result.sv
rtl/regf_top.sv
tb/regf_tb.sv
